/* Makefile */
# Verilator build for the ieu testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ieu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides pass or fail
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/ieu_tests.svh */
// Directed ieu tests; relies on issue, finish_burst, the compare tasks and RESET_CYCLES of the including module
`ifndef IEU_TESTS_SVH
`define IEU_TESTS_SVH

// ============================================================
// instruction encoders, rd=x1 rs1=x2 rs2=x3
// ============================================================
function automatic riscv_pkg::word_t enc_r(input logic [2:0] f3, input logic alt);
    return {1'b0, alt, 5'b0, 5'd3, 5'd2, f3, 5'd1, riscv_pkg::OPCODE_OP};
endfunction

function automatic riscv_pkg::word_t enc_i(input riscv_pkg::opcode_t opc, input logic [2:0] f3,
                                           input logic [11:0] imm);
    return {imm, 5'd2, f3, 5'd1, opc};
endfunction

function automatic riscv_pkg::word_t enc_b(input logic [2:0] f3, input logic [12:0] off);
    return {off[12], off[10:5], 5'd3, 5'd2, f3, off[4:1], off[11], riscv_pkg::OPCODE_BRANCH};
endfunction

function automatic riscv_pkg::word_t enc_u(input riscv_pkg::opcode_t opc,
                                           input logic [19:0] imm);
    return {imm, 5'd1, opc};
endfunction

function automatic riscv_pkg::word_t enc_j(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, riscv_pkg::OPCODE_JAL};
endfunction

function automatic riscv_pkg::addr_t rand_addr();
    return riscv_pkg::addr_t'($urandom) & 32'hffff_fffc;   // word aligned
endfunction

// ============================================================
// tests
// ============================================================
task automatic test_reset();
    repeat (RESET_CYCLES) begin
        @(posedge clk);
        #1;
        check_flag("o_valid in reset", o_valid, 1'b0);
        check_flag("o_wr in reset", o_wr, 1'b0);
        check_flag("o_redirect in reset", o_redirect, 1'b0);
    end
    i_rst = 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_flag("o_valid after reset", o_valid, 1'b0);
    check_flag("o_wr after reset", o_wr, 1'b0);
    check_flag("o_redirect after reset", o_redirect, 1'b0);
endtask

task automatic test_reg_ops();
    logic [2:0] f3;
    repeat (3) begin
        for (int k = 0; k < 10; k++) begin
            f3 = (k == 8) ? 3'b000 : (k == 9) ? 3'b101 : 3'(k);   // 8 is SUB, 9 is SRA
            issue(enc_r(f3, k >= 8), rand_addr(), $urandom, $urandom);
        end
    end
    finish_burst();
endtask

task automatic test_imm_ops();
    logic [2:0]  f3;
    logic [11:0] imm;
    repeat (3) begin
        for (int k = 0; k < 9; k++) begin
            f3  = (k == 8) ? 3'b101 : 3'(k);
            imm = 12'($urandom);
            if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, k == 8, 5'b0, 5'($urandom)};
            issue(enc_i(riscv_pkg::OPCODE_OPIMM, f3, imm), rand_addr(), $urandom, '0);
        end
    end
    // negative immediates, signed and unsigned view
    issue(enc_i(riscv_pkg::OPCODE_OPIMM, 3'b010, 12'hfff), rand_addr(), 32'hffff_fffb, '0);
    issue(enc_i(riscv_pkg::OPCODE_OPIMM, 3'b011, 12'hfff), rand_addr(), 32'h0000_0005, '0);
    finish_burst();
endtask

task automatic test_upper();
    repeat (2) begin
        issue(enc_u(riscv_pkg::OPCODE_LUI, 20'($urandom)), rand_addr(), $urandom, $urandom);
        issue(enc_u(riscv_pkg::OPCODE_AUIPC, 20'($urandom)), rand_addr(), $urandom, $urandom);
    end
    finish_burst();
endtask

task automatic test_branches();
    logic [2:0]       conds [6];
    riscv_pkg::word_t pa [4];
    riscv_pkg::word_t pb [4];
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    pa    = '{32'd5, 32'd7, 32'd3, 32'hffff_ffff};   // last pair: signed less, unsigned greater
    pb    = '{32'd5, 32'd3, 32'd7, 32'd1};
    foreach (conds[c]) begin
        for (int p = 0; p < 4; p++) begin
            issue(enc_b(conds[c], 13'($urandom)), rand_addr(), pa[p], pb[p]);
        end
    end
    finish_burst();
endtask

task automatic test_jumps();
    repeat (2) begin
        issue(enc_j(21'($urandom)), rand_addr(), $urandom, $urandom);
        // odd base plus even offset, target bit 0 must clear
        issue(enc_i(riscv_pkg::OPCODE_JALR, 3'b000, {11'($urandom), 1'b0}), rand_addr(),
              $urandom | 32'd1, $urandom);
    end
    finish_burst();
endtask

`endif

/* bench/ieu_tb.sv */
// Testbench for ieu; results are checked in issue order, o_result only when written, o_target only on redirect
`timescale 1ns/1ps

module ieu_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int N_INSN       = 91;   // issued over all tests
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_INSN + ieu_pkg::IEU_LATENCY + 50;

    typedef struct packed {
        ieu_pkg::tag_t     tag;
        logic              wr;
        riscv_pkg::word_t  result;
        logic              redirect;
        riscv_pkg::addr_t  target;
        int                issue_cyc;
    } exp_t;

    logic              clk;
    logic              i_rst;
    logic              i_valid;
    riscv_pkg::word_t  i_insn;
    riscv_pkg::addr_t  i_iaddr;
    riscv_pkg::word_t  i_src_a;
    riscv_pkg::word_t  i_src_b;
    ieu_pkg::tag_t     i_tag;
    logic              o_valid;
    ieu_pkg::tag_t     o_tag;
    logic              o_wr;
    riscv_pkg::word_t  o_result;
    logic              o_redirect;
    riscv_pkg::addr_t  o_target;

    exp_t           exp_q[$];
    exp_t           head;
    int             cyc;
    int             n_mismatch;
    int             n_proto;
    ieu_pkg::tag_t  next_tag;

    ieu i_dut (
        .clk(clk), .i_rst(i_rst), .i_valid(i_valid), .i_insn(i_insn), .i_iaddr(i_iaddr),
        .i_src_a(i_src_a), .i_src_b(i_src_b), .i_tag(i_tag),
        .o_valid(o_valid), .o_tag(o_tag), .o_wr(o_wr), .o_result(o_result),
        .o_redirect(o_redirect), .o_target(o_target)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ============================================================
    // compare tasks
    // ============================================================
    task automatic check_word(input string what, input riscv_pkg::word_t got,
                              input riscv_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic check_addr(input string what, input riscv_pkg::addr_t got,
                              input riscv_pkg::addr_t exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic check_tag(input string what, input ieu_pkg::tag_t got,
                             input ieu_pkg::tag_t exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
            n_mismatch++;
        end
    endtask

    // ============================================================
    // reference model
    // ============================================================
    function automatic riscv_pkg::word_t arith(input logic [2:0] f3, input logic alt,
                                               input riscv_pkg::word_t a,
                                               input riscv_pkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];   // rv32 uses the low five bits
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? riscv_pkg::word_t'($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model(input riscv_pkg::word_t insn, input riscv_pkg::addr_t iaddr,
                             input riscv_pkg::word_t a, input riscv_pkg::word_t b,
                             output exp_t e);
        riscv_pkg::word_t imm_i;
        riscv_pkg::word_t imm_b;
        riscv_pkg::word_t imm_u;
        riscv_pkg::word_t imm_j;
        logic [2:0]       f3;
        f3    = insn[14:12];
        imm_i = {{20{insn[31]}}, insn[31:20]};
        imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        imm_u = {insn[31:12], 12'b0};
        imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
        e     = '0;
        e.wr  = 1'b1;
        case (insn[6:0])
            riscv_pkg::OPCODE_OP:    e.result = arith(f3, insn[30], a, b);
            riscv_pkg::OPCODE_OPIMM: e.result = arith(f3, insn[30] && f3 == 3'b101, a, imm_i);
            riscv_pkg::OPCODE_LUI:   e.result = imm_u;
            riscv_pkg::OPCODE_AUIPC: e.result = iaddr + imm_u;
            riscv_pkg::OPCODE_BRANCH: begin
                e.wr     = 1'b0;
                e.target = iaddr + imm_b;
                case (f3)
                    3'b000:  e.redirect = a == b;
                    3'b001:  e.redirect = a != b;
                    3'b100:  e.redirect = $signed(a) < $signed(b);
                    3'b101:  e.redirect = $signed(a) >= $signed(b);
                    3'b110:  e.redirect = a < b;
                    default: e.redirect = a >= b;
                endcase
            end
            riscv_pkg::OPCODE_JAL: begin
                e.result   = iaddr + riscv_pkg::INSN_STEP;
                e.redirect = 1'b1;
                e.target   = iaddr + imm_j;
            end
            riscv_pkg::OPCODE_JALR: begin
                e.result   = iaddr + riscv_pkg::INSN_STEP;
                e.redirect = 1'b1;
                e.target   = (a + imm_i) & ~32'd1;
            end
            default: e.result = a + b;   // never issued
        endcase
    endtask

    // ============================================================
    // driver and monitor
    // ============================================================
    task automatic issue(input riscv_pkg::word_t insn, input riscv_pkg::addr_t iaddr,
                         input riscv_pkg::word_t a, input riscv_pkg::word_t b);
        exp_t e;
        @(posedge clk);
        #1;
        run_model(insn, iaddr, a, b, e);
        e.tag       = next_tag;
        e.issue_cyc = cyc;
        exp_q.push_back(e);
        i_valid  = 1'b1;
        i_insn   = insn;
        i_iaddr  = iaddr;
        i_src_a  = a;
        i_src_b  = b;
        i_tag    = next_tag;
        next_tag = next_tag + 1'b1;
    endtask

    // drop valid and wait until every result has come out
    task automatic finish_burst();
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        while (exp_q.size() > 0) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (!i_rst) begin
            if (o_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0t ns: o_valid high with nothing in flight", $time);
                    n_proto++;
                end else begin
                    head = exp_q.pop_front();
                    if (cyc - head.issue_cyc != ieu_pkg::IEU_LATENCY) begin
                        $display("ERROR at %0t ns: result came %0d cycles after issue", $time,
                                 cyc - head.issue_cyc);
                        n_proto++;
                    end
                    check_tag("o_tag", o_tag, head.tag);
                    check_flag("o_wr", o_wr, head.wr);
                    check_flag("o_redirect", o_redirect, head.redirect);
                    if (head.wr) check_word("o_result", o_result, head.result);
                    if (head.redirect) check_addr("o_target", o_target, head.target);
                end
            end else if (exp_q.size() > 0
                         && cyc - exp_q[0].issue_cyc >= ieu_pkg::IEU_LATENCY) begin
                $display("ERROR at %0t ns: o_valid missing for tag %0h", $time, exp_q[0].tag);
                n_proto++;
                head = exp_q.pop_front();
            end
        end
    end

    always @(posedge clk) begin
        if (cyc >= CYCLE_LIMIT) begin
            $display("ERROR: run stopped after %0d cycles, the tests did not finish", cyc);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    `include "ieu_tests.svh"

    initial begin
        void'($urandom(32'hd5c1_dabe));
        i_rst      = 1'b1;
        i_valid    = 1'b0;
        i_insn     = '0;
        i_iaddr    = '0;
        i_src_a    = '0;
        i_src_b    = '0;
        i_tag      = '0;
        cyc        = 0;
        n_mismatch = 0;
        n_proto    = 0;
        next_tag   = '0;
        test_reset();
        test_reg_ops();
        test_imm_ops();
        test_upper();
        test_branches();
        test_jumps();
        $display("errors: %0d value mismatches, %0d protocol errors", n_mismatch, n_proto);
        if (n_mismatch == 0 && n_proto == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+bench
verilog/riscv_pkg.sv
verilog/ieu_pkg.sv
verilog/ieu_id.sv
verilog/ieu_alu.sv
verilog/ieu_br.sv
verilog/ieu_wb.sv
verilog/ieu.sv
bench/ieu_tb.sv

/* verilog/ieu.sv */
// RV32I integer execution unit with two cycle latency and no stall or back-pressure input
`timescale 1ns/1ps

module ieu (
    input  logic              clk,
    input  logic              i_rst,

    input  logic              i_valid,
    input  riscv_pkg::word_t  i_insn,
    input  riscv_pkg::addr_t  i_iaddr,
    input  riscv_pkg::word_t  i_src_a,
    input  riscv_pkg::word_t  i_src_b,
    input  ieu_pkg::tag_t     i_tag,

    output logic              o_valid,
    output ieu_pkg::tag_t     o_tag,
    output logic              o_wr,
    output riscv_pkg::word_t  o_result,
    output logic              o_redirect,
    output riscv_pkg::addr_t  o_target
);

    // decode outputs
    ieu_pkg::alu_func_t               id_alu_func;
    riscv_pkg::word_t                 id_src_a;
    riscv_pkg::word_t                 id_src_b;
    riscv_pkg::addr_t                 id_iaddr;
    riscv_pkg::word_t                 id_imm_b;
    logic [ieu_pkg::SHAMT_WIDTH-1:0]  id_shamt;
    ieu_pkg::tag_t                    id_tag;
    logic                             id_jmp;
    logic                             id_br;
    logic                             id_valid;

    // execute outputs
    logic              alu_valid;
    ieu_pkg::tag_t     alu_tag;
    riscv_pkg::word_t  alu_result;
    logic              tgt_jmp;
    logic              tgt_br;
    riscv_pkg::addr_t  tgt_target;
    riscv_pkg::addr_t  tgt_link;

    // ============================================================
    // decode, execute, writeback
    // ============================================================
    ieu_id u_id (
        .i_insn(i_insn), .i_iaddr(i_iaddr), .i_src_a(i_src_a), .i_src_b(i_src_b),
        .i_tag(i_tag), .i_valid(i_valid),
        .o_alu_func(id_alu_func), .o_src_a(id_src_a), .o_src_b(id_src_b),
        .o_iaddr(id_iaddr), .o_imm_b(id_imm_b), .o_shamt(id_shamt), .o_tag(id_tag),
        .o_jmp(id_jmp), .o_br(id_br), .o_valid(id_valid)
    );

    ieu_alu u_alu (
        .clk(clk), .i_rst(i_rst), .i_valid(id_valid), .i_tag(id_tag),
        .i_alu_func(id_alu_func), .i_src_a(id_src_a), .i_src_b(id_src_b), .i_shamt(id_shamt),
        .o_valid(alu_valid), .o_tag(alu_tag), .o_result(alu_result)
    );

    ieu_br u_br (   // runs alongside the alu
        .clk(clk), .i_rst(i_rst), .i_valid(id_valid), .i_jmp(id_jmp), .i_br(id_br),
        .i_iaddr(id_iaddr), .i_imm_b(id_imm_b), .i_src_a(id_src_a), .i_src_b(id_src_b),
        .o_jmp(tgt_jmp), .o_br(tgt_br), .o_target(tgt_target), .o_link(tgt_link)
    );

    ieu_wb u_wb (
        .clk(clk), .i_rst(i_rst), .i_valid(alu_valid), .i_tag(alu_tag),
        .i_alu_result(alu_result), .i_jmp(tgt_jmp), .i_br(tgt_br),
        .i_target(tgt_target), .i_link(tgt_link),
        .o_valid(o_valid), .o_wr(o_wr), .o_tag(o_tag), .o_result(o_result),
        .o_redirect(o_redirect), .o_target(o_target)
    );

endmodule

/* verilog/ieu_alu.sv */
// Registered ALU stage; one result per cycle, compare results are 0 or 1 in bit 0
`timescale 1ns/1ps

module ieu_alu (
    input  logic                             clk,
    input  logic                             i_rst,

    input  logic                             i_valid,
    input  ieu_pkg::tag_t                    i_tag,
    input  ieu_pkg::alu_func_t               i_alu_func,
    input  riscv_pkg::word_t                 i_src_a,
    input  riscv_pkg::word_t                 i_src_b,
    input  logic [ieu_pkg::SHAMT_WIDTH-1:0]  i_shamt,

    output logic                             o_valid,
    output ieu_pkg::tag_t                    o_tag,
    output riscv_pkg::word_t                 o_result
);

    riscv_pkg::word_t result_d;
    logic             lt_s;
    logic             lt_u;
    logic             eq;

    // shared compare terms
    assign lt_s = $signed(i_src_a) < $signed(i_src_b);
    assign lt_u = i_src_a < i_src_b;
    assign eq   = i_src_a == i_src_b;

    // ============================================================
    // function select
    // ============================================================
    always_comb begin
        case (i_alu_func)
            ieu_pkg::ALU_FUNC_ADD: result_d = i_src_a + i_src_b;
            ieu_pkg::ALU_FUNC_SUB: result_d = i_src_a - i_src_b;
            ieu_pkg::ALU_FUNC_SLL: result_d = i_src_a << i_shamt;
            ieu_pkg::ALU_FUNC_SRL: result_d = i_src_a >> i_shamt;
            ieu_pkg::ALU_FUNC_SRA: result_d = riscv_pkg::word_t'($signed(i_src_a) >>> i_shamt);
            ieu_pkg::ALU_FUNC_XOR: result_d = i_src_a ^ i_src_b;
            ieu_pkg::ALU_FUNC_OR:  result_d = i_src_a | i_src_b;
            ieu_pkg::ALU_FUNC_AND: result_d = i_src_a & i_src_b;
            ieu_pkg::ALU_FUNC_LT:  result_d = riscv_pkg::word_t'(lt_s);
            ieu_pkg::ALU_FUNC_LTU: result_d = riscv_pkg::word_t'(lt_u);
            ieu_pkg::ALU_FUNC_EQ:  result_d = riscv_pkg::word_t'(eq);
            ieu_pkg::ALU_FUNC_NE:  result_d = riscv_pkg::word_t'(!eq);
            ieu_pkg::ALU_FUNC_GE:  result_d = riscv_pkg::word_t'(!lt_s);
            ieu_pkg::ALU_FUNC_GEU: result_d = riscv_pkg::word_t'(!lt_u);
            default:               result_d = i_src_a + i_src_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        o_tag    <= i_tag;
        o_result <= result_d;
    end

    // valid must be clean once reset has been applied
    a_valid_known: assert property (@(posedge clk) !i_rst |-> !$isunknown(o_valid))
        else $error("ieu_alu: o_valid unknown after reset");

endmodule

/* verilog/ieu_br.sv */
// Registered target stage; jump targets clear bit 0 and no misaligned-target trap is raised
`timescale 1ns/1ps

module ieu_br (
    input  logic              clk,
    input  logic              i_rst,

    input  logic              i_valid,
    input  logic              i_jmp,
    input  logic              i_br,
    input  riscv_pkg::addr_t  i_iaddr,
    input  riscv_pkg::word_t  i_imm_b,
    input  riscv_pkg::word_t  i_src_a,
    input  riscv_pkg::word_t  i_src_b,

    output logic              o_jmp,
    output logic              o_br,
    output riscv_pkg::addr_t  o_target,
    output riscv_pkg::addr_t  o_link
);

    riscv_pkg::addr_t jmp_target;
    riscv_pkg::addr_t br_target;

    // ============================================================
    // target adders
    // ============================================================
    // JAL has iaddr + imm_j here, JALR has rs1 + imm_i
    assign jmp_target = (i_src_a + i_src_b) & ~riscv_pkg::addr_t'(1);
    assign br_target  = i_iaddr + i_imm_b;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_jmp <= 1'b0;
            o_br  <= 1'b0;
        end else begin
            o_jmp <= i_valid & i_jmp;   // flags only for real insns
            o_br  <= i_valid & i_br;
        end
    end

    always_ff @(posedge clk) begin
        o_target <= i_jmp ? jmp_target : br_target;
        o_link   <= i_iaddr + riscv_pkg::addr_t'(riscv_pkg::INSN_STEP);
    end

    // decode exclusivity must survive the register stage
    a_flags_excl: assert property (@(posedge clk) disable iff (i_rst) !(o_jmp && o_br))
        else $error("ieu_br: jump and branch flags both set");

endmodule

/* verilog/ieu_id.sv */
// Combinational RV32I decode; unknown opcodes and reserved branch funct3 run as ADD with no flags
`timescale 1ns/1ps

module ieu_id (
    input  riscv_pkg::word_t                 i_insn,
    input  riscv_pkg::addr_t                 i_iaddr,
    input  riscv_pkg::word_t                 i_src_a,
    input  riscv_pkg::word_t                 i_src_b,
    input  ieu_pkg::tag_t                    i_tag,
    input  logic                             i_valid,

    output ieu_pkg::alu_func_t               o_alu_func,
    output riscv_pkg::word_t                 o_src_a,
    output riscv_pkg::word_t                 o_src_b,
    output riscv_pkg::addr_t                 o_iaddr,
    output riscv_pkg::word_t                 o_imm_b,
    output logic [ieu_pkg::SHAMT_WIDTH-1:0]  o_shamt,
    output ieu_pkg::tag_t                    o_tag,
    output logic                             o_jmp,
    output logic                             o_br,
    output logic                             o_valid
);

    localparam int W = riscv_pkg::DATA_WIDTH;

    riscv_pkg::opcode_t  opcode;
    logic [2:0]          funct3;
    ieu_pkg::alu_func_t  arith_func;

    riscv_pkg::word_t imm_i;
    riscv_pkg::word_t imm_b;
    riscv_pkg::word_t imm_u;
    riscv_pkg::word_t imm_j;

    assign opcode = riscv_pkg::opcode_t'(i_insn[6:0]);
    assign funct3 = i_insn[14:12];

    // ============================================================
    // immediates
    // ============================================================
    assign imm_i = {{(W-11){i_insn[31]}}, i_insn[30:20]};
    assign imm_b = {{(W-12){i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
    assign imm_u = {i_insn[31:12], 12'b0};
    assign imm_j = {{(W-20){i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

    // pass-through to the execute stages
    assign o_iaddr = i_iaddr;
    assign o_imm_b = imm_b;
    assign o_tag   = i_tag;
    assign o_valid = i_valid;

    // shared funct3 map for OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  arith_func = ieu_pkg::ALU_FUNC_ADD;
            3'b001:  arith_func = ieu_pkg::ALU_FUNC_SLL;
            3'b010:  arith_func = ieu_pkg::ALU_FUNC_LT;
            3'b011:  arith_func = ieu_pkg::ALU_FUNC_LTU;
            3'b100:  arith_func = ieu_pkg::ALU_FUNC_XOR;
            3'b101:  arith_func = i_insn[30] ? ieu_pkg::ALU_FUNC_SRA : ieu_pkg::ALU_FUNC_SRL;
            3'b110:  arith_func = ieu_pkg::ALU_FUNC_OR;
            default: arith_func = ieu_pkg::ALU_FUNC_AND;
        endcase
    end

    // ============================================================
    // function, operand and flag select
    // ============================================================
    always_comb begin
        o_alu_func = ieu_pkg::ALU_FUNC_ADD;
        o_src_a    = i_src_a;
        o_src_b    = i_src_b;
        o_shamt    = i_insn[24:20];
        o_jmp      = 1'b0;
        o_br       = 1'b0;
        case (opcode)
            riscv_pkg::OPCODE_OP: begin
                // SUB only exists in the register form
                o_alu_func = (funct3 == 3'b000 && i_insn[30]) ? ieu_pkg::ALU_FUNC_SUB : arith_func;
                o_shamt    = i_src_b[ieu_pkg::SHAMT_WIDTH-1:0];
            end
            riscv_pkg::OPCODE_OPIMM: begin
                o_alu_func = arith_func;
                o_src_b    = imm_i;
            end
            riscv_pkg::OPCODE_BRANCH: begin
                o_br = 1'b1;
                case (funct3)
                    3'b000:  o_alu_func = ieu_pkg::ALU_FUNC_EQ;
                    3'b001:  o_alu_func = ieu_pkg::ALU_FUNC_NE;
                    3'b100:  o_alu_func = ieu_pkg::ALU_FUNC_LT;
                    3'b101:  o_alu_func = ieu_pkg::ALU_FUNC_GE;
                    3'b110:  o_alu_func = ieu_pkg::ALU_FUNC_LTU;
                    3'b111:  o_alu_func = ieu_pkg::ALU_FUNC_GEU;
                    default: o_br       = 1'b0;   // reserved
                endcase
            end
            riscv_pkg::OPCODE_LUI: begin
                o_src_a = '0;
                o_src_b = imm_u;
            end
            riscv_pkg::OPCODE_AUIPC: begin
                o_src_a = i_iaddr;
                o_src_b = imm_u;
            end
            riscv_pkg::OPCODE_JAL: begin
                o_src_a = i_iaddr;   // target adder input
                o_src_b = imm_j;
                o_jmp   = 1'b1;
            end
            riscv_pkg::OPCODE_JALR: begin
                o_src_b = imm_i;
                o_jmp   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/ieu_pkg.sv */
// Execution unit types; tags are carried for ordering checks only and are never reordered
package ieu_pkg;

    // ============================================================
    // pipeline constants
    // ============================================================

    localparam int TAG_WIDTH   = 4;
    localparam int SHAMT_WIDTH = 5;   // rv32 shift amount
    localparam int IEU_LATENCY = 2;   // input edge to o_valid

    typedef logic [TAG_WIDTH-1:0] tag_t;

    // ============================================================
    // alu functions
    // ============================================================

    // compare functions return 0 or 1 in bit 0
    typedef enum logic [3:0] {
        ALU_FUNC_ADD = 4'd0,
        ALU_FUNC_SUB = 4'd1,
        ALU_FUNC_SLL = 4'd2,
        ALU_FUNC_SRL = 4'd3,
        ALU_FUNC_SRA = 4'd4,
        ALU_FUNC_LT  = 4'd5,    // signed
        ALU_FUNC_LTU = 4'd6,
        ALU_FUNC_XOR = 4'd7,
        ALU_FUNC_OR  = 4'd8,
        ALU_FUNC_AND = 4'd9,
        ALU_FUNC_EQ  = 4'd10,
        ALU_FUNC_NE  = 4'd11,
        ALU_FUNC_GE  = 4'd12,   // signed
        ALU_FUNC_GEU = 4'd13
    } alu_func_t;

endpackage

/* verilog/ieu_wb.sv */
// Registered writeback; branches never write, jumps write the link address
`timescale 1ns/1ps

module ieu_wb (
    input  logic              clk,
    input  logic              i_rst,

    input  logic              i_valid,
    input  ieu_pkg::tag_t     i_tag,
    input  riscv_pkg::word_t  i_alu_result,
    input  logic              i_jmp,
    input  logic              i_br,
    input  riscv_pkg::addr_t  i_target,
    input  riscv_pkg::addr_t  i_link,

    output logic              o_valid,
    output logic              o_wr,
    output ieu_pkg::tag_t     o_tag,
    output riscv_pkg::word_t  o_result,
    output logic              o_redirect,
    output riscv_pkg::addr_t  o_target
);

    logic taken;

    // compare result sits in bit 0
    assign taken = i_br & i_alu_result[0];

    // ============================================================
    // control
    // ============================================================
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid    <= 1'b0;
            o_wr       <= 1'b0;
            o_redirect <= 1'b0;
        end else begin
            o_valid    <= i_valid;
            o_wr       <= i_valid & ~i_br;
            o_redirect <= i_valid & (i_jmp | taken);
        end
    end

    always_ff @(posedge clk) begin
        o_tag    <= i_tag;
        o_result <= i_jmp ? i_link : i_alu_result;   // link for JAL/JALR
        o_target <= i_target;
    end

    // alu and target stages advance in step
    a_flags_valid: assert property (@(posedge clk) disable iff (i_rst)
        (i_jmp || i_br) |-> i_valid)
        else $error("ieu_wb: jump or branch flag without valid");

endmodule

/* verilog/riscv_pkg.sv */
// RV32I widths and major opcodes for a core with 32-bit words and no compressed instructions
package riscv_pkg;

    // ============================================================
    // widths and basic types
    // ============================================================

    localparam int DATA_WIDTH = 32;   // register width
    localparam int ADDR_WIDTH = 32;   // instruction address width

    // next sequential instruction
    localparam int INSN_STEP = 4;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // ============================================================
    // major opcodes
    // ============================================================

    // taken straight from insn[6:0]
    // only the integer forms handled by the execution unit are listed
    // so loads, stores, fences and system opcodes fall to the decode default
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,   // reg-reg alu
        OPCODE_OPIMM  = 7'b0010011,   // reg-imm alu
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111
    } opcode_t;

    // funct3 field of every form above sits in insn[14:12]
    // bit 30 picks SUB and SRA

endpackage
